/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = qsim_tb
FILELIST = qsim.f
BUILD    = obj_dir
LOG      = sim.log
FAIL_MSG = Simulation FAILED
PASS_MSG = Simulation PASSED

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Run failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

/* hw/qsim_ctrl.sv */
`timescale 1ns/1ps

module qsim_ctrl import qsim_pkg::*; (
  input  logic clk,
  input  logic reset_n,
  input  logic dut_valid,
  output logic dut_ready,
  output logic load_go,
  output logic apply_go,
  output logic store_go,
  input  logic load_done,
  input  logic apply_done,
  input  logic store_done
);

  ctrl_state_t state;
  ctrl_state_t state_nxt;
  logic        hdr_wait;  // Second HEADER cycle

  // --------------------
  // Next state
  // --------------------
  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (dut_valid && dut_ready) state_nxt = HEADER;
      end
      HEADER: begin
        if (hdr_wait) state_nxt = LOAD;  // Address, then capture
      end
      LOAD: begin
        if (load_done) state_nxt = APPLY;
      end
      APPLY: begin
        if (apply_done) state_nxt = STORE;
      end
      STORE: begin
        if (store_done) state_nxt = IDLE;  // Last write is out this cycle
      end
      default: state_nxt = IDLE;
    endcase
  end

  // --------------------
  // State and ready
  // --------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state     <= IDLE;
      hdr_wait  <= 1'b0;
      dut_ready <= 1'b1;
    end else begin
      state     <= state_nxt;
      hdr_wait  <= (state == HEADER) && !hdr_wait;
      dut_ready <= (state_nxt == IDLE);
    end
  end

  // One unit enabled at a time
  assign load_go  = (state == HEADER) || (state == LOAD);
  assign apply_go = (state == APPLY);
  assign store_go = (state == STORE);

endmodule

/* hw/qsim_gate_engine.sv */
`timescale 1ns/1ps

module qsim_gate_engine import qsim_pkg::*; #(
  parameter int MAX_QUBITS = 2,
  parameter int MAX_GATES  = 4
) (
  input  logic clk,
  input  logic reset_n,
  input  logic apply_go,
  input  logic [$clog2(MAX_QUBITS+1)-1:0] num_qubits,
  input  logic [$clog2(MAX_GATES+1)-1:0]  num_gates,
  output logic [ADDR_W-1:0]     gate_addr,
  input  cplx_t                 gate_data,
  output logic [MAX_QUBITS-1:0] rd_idx,
  input  cplx_t                 rd_data,
  output logic                  row_we,
  output logic [MAX_QUBITS-1:0] row_idx,
  output cplx_t                 row_data,
  output logic                  bank_swap,
  output logic                  apply_done
);

  localparam int GW     = $clog2(MAX_GATES + 1);
  localparam int IDX_W  = MAX_QUBITS;
  localparam int PROD_W = 2 * DATA_W;

  logic [GW-1:0] g;
  logic [IDX_W-1:0] i, j, n_last, s1_row, s2_row;
  logic started, issue, col_end, row_end, last_gate;
  logic s1_vld, s1_first, s1_col_end, s1_row_end, s2_we, s2_swap;
  cplx_t amp_q;  // Front bank amplitude, aligned with gate data
  logic signed [PROD_W-1:0] p_rr, p_ii, p_ri, p_ir;
  logic signed [PROD_W:0]   sum_re, sum_im;
  logic signed [ACC_W-1:0]  term_re, term_im, acc_re, acc_im;

  assign n_last    = IDX_W'((1 << num_qubits) - 1);
  assign col_end   = (j == n_last);
  assign row_end   = (i == n_last);
  assign last_gate = (g == num_gates - GW'(1));
  // Gate m, row i, column j laid out linearly
  assign gate_addr = (ADDR_W'(g) << (2 * num_qubits)) + (ADDR_W'(i) << num_qubits) + ADDR_W'(j);
  assign rd_idx    = j;

  // --------------------
  // Complex product
  // --------------------
  assign p_rr    = PROD_W'(gate_data.re) * PROD_W'(amp_q.re);
  assign p_ii    = PROD_W'(gate_data.im) * PROD_W'(amp_q.im);
  assign p_ri    = PROD_W'(gate_data.re) * PROD_W'(amp_q.im);
  assign p_ir    = PROD_W'(gate_data.im) * PROD_W'(amp_q.re);
  assign sum_re  = (PROD_W + 1)'(p_rr) - (PROD_W + 1)'(p_ii);
  assign sum_im  = (PROD_W + 1)'(p_ri) + (PROD_W + 1)'(p_ir);
  assign term_re = ACC_W'(sum_re >>> FRAC_W);
  assign term_im = ACC_W'(sum_im >>> FRAC_W);

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      {started, issue, s1_vld, s2_we, s2_swap} <= '0;
      g <= '0;
      i <= '0;
      j <= '0;
    end else begin
      s1_vld  <= issue;
      s2_we   <= s1_vld && s1_col_end;
      s2_swap <= s1_vld && s1_col_end && s1_row_end;  // Gate's last row
      if (!apply_go) begin
        started <= 1'b0;
        issue   <= 1'b0;
      end else if (!started) begin
        {started, issue} <= {1'b1, num_gates != '0};
        {g, i, j}        <= '0;
      end else if (issue) begin
        j <= col_end ? '0 : j + 1'b1;
        if (col_end) i <= row_end ? '0 : i + 1'b1;
        if (col_end && row_end) issue <= 1'b0;  // Wait for the swap
      end else if (bank_swap && !last_gate) begin
        g     <= g + 1'b1;
        issue <= 1'b1;
      end
    end
  end

  // Two rows in flight, so acc restarts on the next row's first term
  always_ff @(posedge clk) begin
    amp_q <= rd_data;
    {s1_first, s1_col_end, s1_row_end} <= {j == '0, col_end, row_end};
    {s1_row, s2_row} <= {i, s1_row};
    if (s1_vld) begin
      acc_re <= s1_first ? term_re : acc_re + term_re;
      acc_im <= s1_first ? term_im : acc_im + term_im;
    end
  end

  assign row_we      = s2_we;
  assign row_idx     = s2_row;
  assign row_data.re = acc_re[DATA_W-1:0];  // Low bits only
  assign row_data.im = acc_im[DATA_W-1:0];
  assign bank_swap   = s2_swap;
  assign apply_done  = (s2_swap && last_gate) || (apply_go && (num_gates == '0));

endmodule

/* hw/qsim_loader.sv */
`timescale 1ns/1ps

module qsim_loader import qsim_pkg::*; #(
  parameter int MAX_QUBITS = 2,
  parameter int MAX_GATES  = 4
) (
  input  logic                          clk,
  input  logic                          reset_n,
  input  logic                          load_go,
  output logic [ADDR_W-1:0]             state_in_addr,
  input  cplx_t                         state_in_data,
  output logic [$clog2(MAX_QUBITS+1)-1:0] num_qubits,
  output logic [$clog2(MAX_GATES+1)-1:0]  num_gates,
  output logic                          load_we,
  output logic [MAX_QUBITS-1:0]         load_idx,
  output cplx_t                         load_data,
  output logic                          load_done
);

  localparam int QB_W  = $clog2(MAX_QUBITS + 1);
  localparam int GW    = $clog2(MAX_GATES + 1);
  localparam int IDX_W = MAX_QUBITS;
  localparam int CNT_W = MAX_QUBITS + 2;  // Reaches 2^q + 4

  logic [CNT_W-1:0] cnt;    // Cycles since load_go rose
  logic [CNT_W-1:0] n_amp;  // 2^q

  assign n_amp = CNT_W'(1) << num_qubits;

  // Header at 0 for two cycles, then 1..N
  assign state_in_addr = ADDR_W'((cnt == '0) ? cnt : cnt - 1'b1);

  // Data lags the address by one cycle
  assign load_we   = load_go && (cnt >= CNT_W'(3)) && (cnt <= n_amp + CNT_W'(2));
  assign load_idx  = IDX_W'(cnt - CNT_W'(3));
  assign load_data = state_in_data;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      cnt        <= '0;
      num_qubits <= '0;
      num_gates  <= '0;
      load_done  <= 1'b0;
    end else begin
      cnt       <= load_go ? cnt + 1'b1 : '0;
      load_done <= load_go && (cnt == n_amp + CNT_W'(2));
      if (load_go && (cnt == CNT_W'(1))) begin  // Header word on the bus
        num_qubits <= state_in_data.re[QB_W-1:0];
        num_gates  <= state_in_data.im[GW-1:0];
      end
    end
  end

endmodule

/* hw/qsim_pkg.sv */
package qsim_pkg;

  // --------------------
  // Data widths
  // --------------------
  localparam int DATA_W = 16;  // One real or imaginary component
  localparam int FRAC_W = 13;  // Fraction bits of Q2.13
  localparam int ACC_W  = 40;  // Row accumulator per component
  localparam int ADDR_W = 8;   // SRAM address width

  // One amplitude, one gate entry or one SRAM word
  // Header word carries q in re and m in im
  typedef struct packed {
    logic signed [DATA_W-1:0] re;
    logic signed [DATA_W-1:0] im;
  } cplx_t;

  // Output SRAM write port
  typedef struct packed {
    logic              en;
    logic [ADDR_W-1:0] addr;
    cplx_t             data;
  } out_wr_t;

  // --------------------
  // Controller states
  // --------------------
  typedef enum logic [2:0] {
    IDLE,
    HEADER,
    LOAD,
    APPLY,
    STORE
  } ctrl_state_t;

endpackage

/* hw/qsim_state_bank.sv */
`timescale 1ns/1ps

module qsim_state_bank import qsim_pkg::*; #(
  parameter int MAX_QUBITS = 2
) (
  input  logic                            clk,
  input  logic                            reset_n,
  input  logic                            load_we,
  input  logic [MAX_QUBITS-1:0]           load_idx,
  input  cplx_t                           load_data,
  input  logic [MAX_QUBITS-1:0]           rd_idx,
  output cplx_t                           rd_data,
  input  logic                            row_we,
  input  logic [MAX_QUBITS-1:0]           row_idx,
  input  cplx_t                           row_data,
  input  logic                            bank_swap,
  input  logic                            store_go,
  input  logic [$clog2(MAX_QUBITS+1)-1:0] num_qubits,
  output out_wr_t                         state_out_wr,
  output logic                            store_done
);

  localparam int IDX_W   = MAX_QUBITS;
  localparam int NUM_AMP = 1 << MAX_QUBITS;

  cplx_t            mem [2][NUM_AMP];  // Two banks
  logic             front;             // Bank read by the engine
  logic [IDX_W:0]   st_cnt;
  logic [IDX_W:0]   n_amp;

  assign n_amp   = (IDX_W + 1)'(1) << num_qubits;
  assign rd_data = mem[front][rd_idx];

  // --------------------
  // Bank writes
  // --------------------
  always_ff @(posedge clk) begin
    if (load_we) mem[front][load_idx] <= load_data;  // Initial vector
    if (row_we) mem[~front][row_idx] <= row_data;    // Next vector
  end

  always_ff @(posedge clk) begin
    if (!reset_n) front <= 1'b0;
    else          front <= front ^ bank_swap;
  end

  // --------------------
  // Output SRAM stream
  // --------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      st_cnt       <= '0;
      state_out_wr <= '0;
      store_done   <= 1'b0;
    end else begin
      state_out_wr.en <= 1'b0;
      store_done      <= 1'b0;
      if (!store_go) begin
        st_cnt <= '0;
      end else if (st_cnt < n_amp) begin
        state_out_wr.en   <= 1'b1;
        state_out_wr.addr <= ADDR_W'(st_cnt);
        state_out_wr.data <= mem[front][st_cnt[IDX_W-1:0]];
        st_cnt            <= st_cnt + 1'b1;
        store_done        <= (st_cnt == n_amp - 1'b1);  // Rides with last write
      end
    end
  end

endmodule

/* hw/qsim_top.sv */
`timescale 1ns/1ps

module qsim_top import qsim_pkg::*; #(
  parameter int MAX_QUBITS = 2,
  parameter int MAX_GATES  = 4
) (
  input  logic              clk,
  input  logic              reset_n,
  input  logic              dut_valid,
  output logic              dut_ready,
  output logic [ADDR_W-1:0] state_in_addr,
  input  cplx_t             state_in_data,
  output logic [ADDR_W-1:0] gate_addr,
  input  cplx_t             gate_data,
  output out_wr_t           state_out_wr
);

  localparam int QB_W  = $clog2(MAX_QUBITS + 1);
  localparam int GW    = $clog2(MAX_GATES + 1);
  localparam int IDX_W = MAX_QUBITS;

  logic             load_go, apply_go, store_go;
  logic             load_done, apply_done, store_done;
  logic [QB_W-1:0]  num_qubits;
  logic [GW-1:0]    num_gates;

  logic             load_we;  // Loader into front bank
  logic [IDX_W-1:0] load_idx;
  cplx_t            load_data;

  logic [IDX_W-1:0] rd_idx;   // Engine front bank read
  cplx_t            rd_data;
  logic             row_we;   // Engine into back bank
  logic [IDX_W-1:0] row_idx;
  cplx_t            row_data;
  logic             bank_swap;

  qsim_ctrl u_ctrl (
    .clk(clk), .reset_n(reset_n),
    .dut_valid(dut_valid), .dut_ready(dut_ready),
    .load_go(load_go), .apply_go(apply_go), .store_go(store_go),
    .load_done(load_done), .apply_done(apply_done), .store_done(store_done)
  );

  qsim_loader #(.MAX_QUBITS(MAX_QUBITS), .MAX_GATES(MAX_GATES)) u_loader (
    .clk(clk), .reset_n(reset_n), .load_go(load_go),
    .state_in_addr(state_in_addr), .state_in_data(state_in_data),
    .num_qubits(num_qubits), .num_gates(num_gates),
    .load_we(load_we), .load_idx(load_idx), .load_data(load_data),
    .load_done(load_done)
  );

  qsim_state_bank #(.MAX_QUBITS(MAX_QUBITS)) u_bank (
    .clk(clk), .reset_n(reset_n),
    .load_we(load_we), .load_idx(load_idx), .load_data(load_data),
    .rd_idx(rd_idx), .rd_data(rd_data),
    .row_we(row_we), .row_idx(row_idx), .row_data(row_data),
    .bank_swap(bank_swap), .store_go(store_go), .num_qubits(num_qubits),
    .state_out_wr(state_out_wr), .store_done(store_done)
  );

  qsim_gate_engine #(.MAX_QUBITS(MAX_QUBITS), .MAX_GATES(MAX_GATES)) u_engine (
    .clk(clk), .reset_n(reset_n), .apply_go(apply_go),
    .num_qubits(num_qubits), .num_gates(num_gates),
    .gate_addr(gate_addr), .gate_data(gate_data),
    .rd_idx(rd_idx), .rd_data(rd_data),
    .row_we(row_we), .row_idx(row_idx), .row_data(row_data),
    .bank_swap(bank_swap), .apply_done(apply_done)
  );

endmodule

/* qsim.f */
hw/qsim_pkg.sv
hw/qsim_ctrl.sv
hw/qsim_loader.sv
hw/qsim_state_bank.sv
hw/qsim_gate_engine.sv
hw/qsim_top.sv
tb/qsim_props.sv
tb/qsim_tb.sv

/* tb/qsim_props.sv */
`timescale 1ns/1ps

module qsim_props import qsim_pkg::*; (
  input logic    clk,
  input logic    reset_n,
  input logic    dut_ready,
  input out_wr_t state_out_wr
);

  // --------------------
  // Handshake
  // --------------------
  a_ready_no_write: assert property (
    @(posedge clk) disable iff (!reset_n) !(dut_ready && state_out_wr.en)
  ) else $error("dut_ready high in the same cycle as an output write");

  a_ready_after_reset: assert property (
    @(posedge clk) $rose(reset_n) |-> dut_ready
  ) else $error("dut_ready low on the first cycle after reset");

  // --------------------
  // Output write port
  // --------------------
  a_addr_step: assert property (
    @(posedge clk) disable iff (!reset_n)
      (state_out_wr.en && $past(state_out_wr.en))
        |-> (state_out_wr.addr == $past(state_out_wr.addr) + ADDR_W'(1))
  ) else $error("Consecutive output writes do not step the address by one");

endmodule

/* tb/qsim_tb.sv */
`timescale 1ns/1ps

module qsim_tb import qsim_pkg::*; ();

  localparam int CLK_PERIOD = 100;
  localparam int RESET_CYC  = 8;
  localparam int SEED       = 36930;
  localparam int MAX_Q      = 2;
  localparam int MAX_M      = 4;
  localparam int ONE        = 1 << FRAC_W;
  localparam int HALF_RT2   = 5793;              // 1/sqrt(2) in Q2.13
  localparam int RND_LIM    = 1 << (FRAC_W - 2);
  localparam int NUM_JOBS   = 7;
  // Worst case covers header, load, every gate row by row and store
  localparam int JOB_CYC    = 2 + ((1 << MAX_Q) + 4) + MAX_M * ((1 << (2 * MAX_Q)) + 4)
                              + (1 << MAX_Q) + 8;
  localparam int WATCHDOG_CYC = RESET_CYC + NUM_JOBS * (JOB_CYC + 20) + 200;

  logic              clk;
  logic              reset_n;
  logic              dut_valid;
  logic              dut_ready;
  logic [ADDR_W-1:0] state_in_addr;
  logic [ADDR_W-1:0] gate_addr;
  logic [ADDR_W-1:0] state_addr_q = '0;
  logic [ADDR_W-1:0] gate_addr_q = '0;
  cplx_t             state_in_data = '0;
  cplx_t             gate_data = '0;
  out_wr_t           state_out_wr;

  cplx_t state_mem [256];  // Header at 0, amplitudes from 1
  cplx_t gate_mem [256];
  cplx_t exp_vec [4];
  int    n_exp = 4;
  int    wr_idx = 0;
  int    total_writes = 0;
  int    data_errors = 0;
  int    check_errors = 0;
  string test_name = "reset";

  qsim_top #(.MAX_QUBITS(MAX_Q), .MAX_GATES(MAX_M)) u_qsim_top (
    .clk(clk), .reset_n(reset_n),
    .dut_valid(dut_valid), .dut_ready(dut_ready),
    .state_in_addr(state_in_addr), .state_in_data(state_in_data),
    .gate_addr(gate_addr), .gate_data(gate_data),
    .state_out_wr(state_out_wr)
  );

  bind qsim_top qsim_props u_props (
    .clk(clk), .reset_n(reset_n), .dut_ready(dut_ready), .state_out_wr(state_out_wr)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // --------------------
  // SRAM models
  // --------------------
  always @(posedge clk) begin
    state_addr_q <= state_in_addr;
    gate_addr_q  <= gate_addr;
  end

  always @(negedge clk) begin  // Data one cycle after the address
    state_in_data <= state_mem[state_addr_q];
    gate_data     <= gate_mem[gate_addr_q];
  end

  function automatic cplx_t make_cplx(input int re, input int im);
    cplx_t c;
    c.re = DATA_W'(re);
    c.im = DATA_W'(im);
    return c;
  endfunction

  function automatic cplx_t rand_cplx();
    return make_cplx(int'($urandom_range(2 * RND_LIM - 2)) - (RND_LIM - 1),
                     int'($urandom_range(2 * RND_LIM - 2)) - (RND_LIM - 1));
  endfunction

  // Product terms truncated by FRAC_W and rows wrapped to DATA_W after each gate
  function automatic void compute_expected(input int q, input int m);
    longint vr [4];
    longint vi [4];
    longint nr [4];
    longint ni [4];
    longint gr;
    longint gi;
    longint acc_r;
    longint acc_i;
    int     n;
    n = 1 << q;
    for (int k = 0; k < n; k++) begin
      vr[k] = state_mem[k + 1].re;
      vi[k] = state_mem[k + 1].im;
    end
    for (int g = 0; g < m; g++) begin
      for (int i = 0; i < n; i++) begin
        acc_r = 0;
        acc_i = 0;
        for (int j = 0; j < n; j++) begin
          gr = gate_mem[g * n * n + i * n + j].re;
          gi = gate_mem[g * n * n + i * n + j].im;
          acc_r += (gr * vr[j] - gi * vi[j]) >>> FRAC_W;
          acc_i += (gr * vi[j] + gi * vr[j]) >>> FRAC_W;
        end
        nr[i] = $signed(acc_r[DATA_W-1:0]);
        ni[i] = $signed(acc_i[DATA_W-1:0]);
      end
      vr = nr;
      vi = ni;
    end
    for (int k = 0; k < n; k++) exp_vec[k] = make_cplx(int'(vr[k]), int'(vi[k]));
  endfunction

  task automatic clear_mems();
    for (int a = 0; a < 256; a++) begin
      state_mem[a] = make_cplx(a * 37 + 5, a ^ 'hc3);
      gate_mem[a]  = make_cplx(a * 91 + 3, ~a);
    end
  endtask

  task automatic fill_random(input int q, input int m);
    clear_mems();
    for (int k = 1; k <= (1 << q); k++) state_mem[k] = rand_cplx();
    for (int a = 0; a < m * (1 << (2 * q)); a++) gate_mem[a] = rand_cplx();
  endtask

  // One full job with an optional stray dut_valid while busy
  task automatic run_job(input string name, input int q, input int m, input bit busy_pulse);
    int start_writes;
    test_name       = name;
    n_exp           = 1 << q;
    state_mem[0]    = make_cplx(q, m);
    compute_expected(q, m);
    start_writes    = total_writes;
    @(negedge clk);
    dut_valid = 1'b1;
    @(negedge clk);
    dut_valid = 1'b0;
    if (dut_ready !== 1'b0) begin
      $display("Mismatch %s dut_ready after accept expected 0 actual %b", name, dut_ready);
      check_errors++;
    end
    if (busy_pulse) begin
      repeat (3) @(negedge clk);
      dut_valid = 1'b1;  // Must be ignored
      @(negedge clk);
      dut_valid = 1'b0;
    end
    while (dut_ready !== 1'b1) @(negedge clk);
    if (total_writes - start_writes != n_exp) begin
      $display("Mismatch %s write count expected %0d actual %0d", name, n_exp,
               total_writes - start_writes);
      check_errors++;
    end
    if (busy_pulse) begin
      repeat (10) @(negedge clk);
      if (dut_ready !== 1'b1 || total_writes - start_writes != n_exp) begin
        $display("%s: a second job started from dut_valid while busy", name);
        check_errors++;
      end
    end
  endtask

  // --------------------
  // Output compare
  // --------------------
  always @(negedge clk) begin
    if (dut_ready) wr_idx = 0;
    if (reset_n && state_out_wr.en) begin
      total_writes++;
      if (wr_idx >= n_exp) begin
        $display("%s: output write beyond the expected amplitude count", test_name);
        data_errors++;
      end else if (state_out_wr.addr !== ADDR_W'(wr_idx)) begin
        $display("Mismatch %s address expected %0d actual %0d", test_name, wr_idx,
                 state_out_wr.addr);
        data_errors++;
      end else if (state_out_wr.data !== exp_vec[wr_idx]) begin
        $display("Mismatch %s amp %0d expected (%0d,%0d) actual (%0d,%0d)", test_name,
                 wr_idx, exp_vec[wr_idx].re, exp_vec[wr_idx].im,
                 state_out_wr.data.re, state_out_wr.data.im);
        data_errors++;
      end
      wr_idx++;
    end
  end

  initial begin
    void'($urandom(SEED));
    reset_n   = 1'b0;
    dut_valid = 1'b0;
    clear_mems();
    repeat (RESET_CYC) @(negedge clk);
    reset_n = 1'b1;
    @(negedge clk);
    if (dut_ready !== 1'b1) begin
      $display("Mismatch reset dut_ready expected 1 actual %b", dut_ready);
      check_errors++;
    end

    fill_random(2, 0);
    run_job("zero_gates", 2, 0, 1'b0);

    clear_mems();                        // Pauli-X swap
    state_mem[1] = make_cplx(4915, -1638);
    state_mem[2] = make_cplx(2000, 3000);
    gate_mem[0]  = make_cplx(0, 0);
    gate_mem[1]  = make_cplx(ONE, 0);
    gate_mem[2]  = make_cplx(ONE, 0);
    gate_mem[3]  = make_cplx(0, 0);
    run_job("pauli_x", 1, 1, 1'b0);
    state_mem[1] = make_cplx(3000, -1000);
    state_mem[2] = make_cplx(-2500, 1500);
    gate_mem[0]  = make_cplx(HALF_RT2, 0);
    gate_mem[1]  = make_cplx(HALF_RT2, 0);
    gate_mem[2]  = make_cplx(HALF_RT2, 0);
    gate_mem[3]  = make_cplx(-HALF_RT2, 0);
    run_job("hadamard", 1, 1, 1'b0);

    fill_random(2, 4);
    run_job("random_gates", 2, 4, 1'b0);

    fill_random(2, 2);
    run_job("handshake", 2, 2, 1'b1);

    fill_random(1, 2);                   // q changes between jobs
    run_job("back_to_back_q1", 1, 2, 1'b0);
    fill_random(2, 3);
    run_job("back_to_back_q2", 2, 3, 1'b0);

    $display("Errors: data=%0d checks=%0d", data_errors, check_errors);
    if (data_errors + check_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // --------------------
  // Watchdog
  // --------------------
  initial begin
    #(WATCHDOG_CYC * CLK_PERIOD);
    $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYC);
    $display("Simulation FAILED");
    $finish;
  end

endmodule
